// File: filelist.f
+incdir+verilog
verilog/mseqUwordPkg.sv
verilog/mseqDiagPkg.sv
verilog/sbrStack.sv
verilog/diagRegs.sv
verilog/crAddr.sv
verilog/cramStore.sv
verilog/mseqTop.sv
dv/mseqTb.sv

// File: Bender.yml
package:
  name: mseq

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mseqUwordPkg.sv
      - verilog/mseqDiagPkg.sv
      - verilog/sbrStack.sv
      - verilog/diagRegs.sv
      - verilog/crAddr.sv
      - verilog/cramStore.sv
      - verilog/mseqTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/mseqTb.sv

// File: dv/mseq_input.txt
# L <adr> <microword>   load one control-store word, all hex
# S <run> <forceAdr> <condIn> <irJ> <expAdr> <diagFunc> <expRdData>   one step, all hex
#
# Microcode image, the last load leaves the diagnostic address at 5A5
L 000 020001
L 010 040002
L 020 0604C3
L 031 080544
L 040 080805
L 054 340206
L 1A0 580207
L 2C0 600208
L 300 002C09
L 2C1 002C0A
L 1A1 004C0B
L 056 10000C
L 080 14020D
L 0A0 18020E
L 0C0 1A000F
L 0D0 000011
L 7FF 00103F
L 5A5 000C10
# Plain jumps, skip on condIn bit 3 set, skip on bit 5 clear, irJ dispatch
S 1 0 00 0 010 6 10
S 1 0 00 0 020 7 00
S 1 0 08 0 031 0 00
S 1 0 DF 0 040 0 00
S 1 0 00 A 054 6 54
# Three nested calls, then three returns
S 1 0 00 0 1A0 8 54
S 1 0 00 0 2C0 9 01
S 1 0 00 0 300 A 07
S 1 0 00 0 2C1 8 A0
S 1 0 00 0 1A1 8 54
S 1 0 00 0 056 6 56
# Stall with run low
S 0 0 00 0 056 7 00
S 0 0 00 0 056 6 56
# Two calls, then force with run low
S 1 0 00 0 080 0 00
S 1 0 00 0 0A0 A 23
S 1 0 00 0 0C0 A 05
S 0 1 00 0 7FF A 22
# Diagnostic dispatch, return to the forced-from address, wrap to start
S 1 0 00 0 5A5 8 C0
S 1 0 00 0 0C0 A 01
S 1 0 00 0 0D0 6 D0
S 1 0 00 0 000 0 00
S 1 0 00 0 010 6 10

// File: dv/mseqTb.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Self-checking testbench for the microcode sequencer
// Image and per-step expectations come from dv/mseq_input.txt
module mseqTb
  import mseqUwordPkg::*;
  import mseqDiagPkg::*;
();

  logic                    CLK;
  logic                    rstN;
  logic                    run;
  logic                    forceAdr;
  logic [7:0]              condIn;
  logic [3:0]              irJ;
  logic [3:0]              diagFunc;
  logic [`MSEQ_DIAG_W-1:0] diagWrData;
  logic [`MSEQ_DIAG_W-1:0] diagRdData;
  logic [`MSEQ_ADR_W-1:0]  crAdr;
  logic [5:0]              uOut;
  logic                    dispParity;

  // Shadow of every word loaded into the control store
  uword_t image [`MSEQ_CRAM_WORDS];
  // Input records, comments dropped
  string recs [$];
  // Address the sequencer should hold right now
  logic [`MSEQ_ADR_W-1:0] curAdr;
  int cycles;
  int cycleLimit;
  int unsigned seedVal;

  mseqTop UUT (
    .CLK        (CLK),
    .rstN       (rstN),
    .run        (run),
    .forceAdr   (forceAdr),
    .condIn     (condIn),
    .irJ        (irJ),
    .diagFunc   (diagFunc),
    .diagWrData (diagWrData),
    .diagRdData (diagRdData),
    .crAdr      (crAdr),
    .uOut       (uOut),
    .dispParity (dispParity)
  );

  // 20 ns clock
  always #10 CLK = ~CLK;

  // Watchdog on total cycles
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout: no result after %0d clock cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic rejectRecord(input string rec);
    $display("Malformed record in input file: %s", rec);
    $display("SIMULATION FAILED");
    $fatal(1, "bad input record");
  endtask

  task automatic readInput;
    int fd;
    string line;
    fd = $fopen("dv/mseq_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/mseq_input.txt for reading");
      $display("SIMULATION FAILED");
      $fatal(1, "missing input file");
    end
    while ($fgets(line, fd) > 0) begin
      // Blank lines and # comments
      if (line.len() > 1 && line.getc(0) != "#") begin
        recs.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // Load one word, five diagnostic cycles
  task automatic loadWord(input string rec);
    int adr;
    int word;
    if ($sscanf(rec, "L %h %h", adr, word) != 2) begin
      rejectRecord(rec);
    end
    diagFunc   = DF_ADR_HI;
    diagWrData = 8'(adr[10:8]);
    @(negedge CLK);
    diagFunc   = DF_ADR_LO;
    diagWrData = adr[7:0];
    @(negedge CLK);
    // Low byte first, B2 commits
    diagFunc   = DF_WR_B0;
    diagWrData = word[7:0];
    @(negedge CLK);
    diagFunc   = DF_WR_B1;
    diagWrData = word[15:8];
    @(negedge CLK);
    diagFunc   = DF_WR_B2;
    diagWrData = word[23:16];
    @(negedge CLK);
    diagFunc   = DF_IDLE;
    diagWrData = '0;
    image[adr[10:0]] = uword_t'(word[23:0]);
  endtask

  // One sequencer cycle, outputs checked at the next falling edge
  task automatic stepSequencer(input string rec);
    int r;
    int f;
    int c;
    int j;
    int e;
    int fn;
    int rd;
    if ($sscanf(rec, "S %h %h %h %h %h %h %h", r, f, c, j, e, fn, rd) != 7) begin
      rejectRecord(rec);
    end
    run      = r[0];
    forceAdr = f[0];
    irJ      = j[3:0];
    diagFunc = fn[3:0];
    // condIn only matters under a skip word
    if (image[curAdr].disp == DISP_SKIP) begin
      condIn = c[7:0];
    end else begin
      condIn = 8'($urandom);
    end
    @(negedge CLK);
    checkValue("crAdr", 32'(crAdr), 32'(e[10:0]));
    checkValue("uOut", 32'(uOut), 32'(image[e[10:0]].uOut));
    // Parity over call bit and disp field
    checkValue("dispParity", 32'(dispParity),
               32'(^{image[e[10:0]].call, image[e[10:0]].disp}));
    checkValue("diagRdData", 32'(diagRdData), 32'(rd[7:0]));
    curAdr = e[10:0];
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK        = 1'b0;
    rstN       = 1'b0;
    run        = 1'b0;
    forceAdr   = 1'b0;
    condIn     = '0;
    irJ        = '0;
    diagFunc   = DF_IDLE;
    diagWrData = '0;
    cycles     = 0;
    curAdr     = '0;
    cycleLimit = 100;
    // Seed once for the don't-care condition inputs
    seedVal    = $urandom(24776);
    readInput();
    cycleLimit = 2 * recs.size() + 100;
    // Reset for 8 cycles
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    checkValue("crAdr", 32'(crAdr), 32'h0);
    checkValue("diagRdData", 32'(diagRdData), 32'h0);
    rstN = 1'b1;
    foreach (recs[i]) begin
      case (recs[i].getc(0))
        "L": loadWord(recs[i]);
        "S": stepSequencer(recs[i]);
        default: rejectRecord(recs[i]);
      endcase
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog/mseqTop.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Microcode sequencer top level
module mseqTop
  import mseqUwordPkg::*;
  import mseqDiagPkg::*;
(
  input  logic                    CLK,
  input  logic                    rstN,
  // Sequencer controls
  input  logic                    run,
  input  logic                    forceAdr,
  input  logic [7:0]              condIn,
  input  logic [3:0]              irJ,
  // Diagnostic port
  input  logic [3:0]              diagFunc,
  input  logic [`MSEQ_DIAG_W-1:0] diagWrData,
  output logic [`MSEQ_DIAG_W-1:0] diagRdData,
  // Sequencer outputs
  output logic [`MSEQ_ADR_W-1:0]  crAdr,
  output logic [5:0]              uOut,
  output logic                    dispParity
);

  // Microword at crAdr
  uword_t                uw;
  logic [`MSEQ_SP_W-1:0] spOut;

  sbrIf  sbr ();
  diagIf diag ();

  crAddr uCrAddr (
    .CLK        (CLK),
    .rstN       (rstN),
    .run        (run),
    .forceAdr   (forceAdr),
    .condIn     (condIn),
    .irJ        (irJ),
    .uw         (uw),
    .sbr        (sbr.seq),
    .diag       (diag.seq),
    .crAdr      (crAdr),
    .dispParity (dispParity)
  );

  sbrStack uSbrStack (
    .CLK   (CLK),
    .rstN  (rstN),
    .sbr   (sbr.stack),
    .spOut (spOut)
  );

  cramStore uCramStore (
    .CLK   (CLK),
    .crAdr (crAdr),
    .diag  (diag.store),
    .uw    (uw)
  );

  // Function code arrives as plain bits
  diagRegs uDiagRegs (
    .CLK        (CLK),
    .rstN       (rstN),
    .diagFunc   (diagFunc_t'(diagFunc)),
    .diagWrData (diagWrData),
    .crAdr      (crAdr),
    .retAdr     (sbr.retAdr),
    .spOut      (spOut),
    .dispParity (dispParity),
    .run        (run),
    .diag       (diag.regs),
    .diagRdData (diagRdData)
  );

  assign uOut = uw.uOut;

endmodule

// File: verilog/cramStore.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Control store, 2K microwords
// Loaded only through the diagnostic path, not cleared by reset
module cramStore
  import mseqUwordPkg::*;
(
  input  logic                   CLK,
  input  logic [`MSEQ_ADR_W-1:0] crAdr,
  diagIf.store                   diag,
  output uword_t                 uw
);

  //////////////////////////////////////////////////////////////////////
  // Storage array
  //////////////////////////////////////////////////////////////////////

  uword_t cram [`MSEQ_CRAM_WORDS];

  // Current microword, asynchronous read
  assign uw = cram[crAdr];

  // Diagnostic commit
  // Word is assembled by diagRegs, one strobe writes all 24 bits
  always_ff @(posedge CLK) begin
    if (diag.wrEn) begin
      cram[diag.wrAdr] <= diag.wrWord;
    end
  end

endmodule

// File: verilog/crAddr.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Control-RAM address sequencer
// Next address = jump field OR one dispatch source, or 7FF on force
module crAddr
  import mseqUwordPkg::*;
(
  input  logic                   CLK,
  input  logic                   rstN,
  input  logic                   run,
  input  logic                   forceAdr,
  input  logic [7:0]             condIn,
  input  logic [3:0]             irJ,
  input  uword_t                 uw,
  sbrIf.seq                      sbr,
  diagIf.seq                     diag,
  output logic [`MSEQ_ADR_W-1:0] crAdr,
  output logic                   dispParity
);

  // Sequencer steps this cycle
  logic advance;
  // Microword asks for a return
  logic isRet;
  // Condition bit chosen by the cond field
  logic skipBit;
  // Dispatch source ORed into the jump field
  logic [`MSEQ_ADR_W-1:0] dispMux;
  logic [`MSEQ_ADR_W-1:0] nextAdr;

  // Force steps even with run low
  assign advance = run | forceAdr;
  assign isRet   = (uw.disp == DISP_RET);
  assign skipBit = condIn[uw.cond];

  //////////////////////////////////////////////////////////////////////
  // Dispatch mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dispMux = '0;
    case (uw.disp)
      DISP_SKIP: begin
        // Skip lands in bit 0 only
        dispMux[0] = skipBit;
      end
      DISP_IRJ: begin
        // Nibble dispatch, 2-word spacing
        dispMux[4:1] = irJ;
      end
      DISP_RET: begin
        dispMux = sbr.retAdr;
      end
      DISP_DIAG: begin
        dispMux = diag.diagAdr;
      end
      default: begin
        // DISP_NONE and unused codes
        dispMux = '0;
      end
    endcase
  end

  // Force overrides everything
  assign nextAdr = forceAdr ? '1 : (uw.jump | dispMux);

  //////////////////////////////////////////////////////////////////////
  // Stack control
  //////////////////////////////////////////////////////////////////////

  // Call pushes the address of the calling word
  // Force also pushes, it counts as a call
  assign sbr.push    = advance & (uw.call | forceAdr);
  // Force raises pop too so the stack sees a reload
  // a call bit on a return word makes it a plain push
  assign sbr.pop     = advance & (forceAdr | (isRet & ~uw.call));
  assign sbr.pushAdr = crAdr;

  //////////////////////////////////////////////////////////////////////
  // Address register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      crAdr <= '0;
    end else if (advance) begin
      crAdr <= nextAdr;
    end
  end

  // Parity over call and dispatch bits, for diagnostics
  assign dispParity = ^{uw.call, uw.disp};

endmodule

// File: verilog/diagRegs.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Diagnostic block to sequencer and control store
interface diagIf
  import mseqUwordPkg::*;
();
  logic [`MSEQ_ADR_W-1:0] diagAdr;
  // Commit strobe, one cycle
  logic                   wrEn;
  logic [`MSEQ_ADR_W-1:0] wrAdr;
  uword_t                 wrWord;

  modport regs (output diagAdr, output wrEn, output wrAdr, output wrWord);
  modport seq (input diagAdr);
  modport store (input wrEn, input wrAdr, input wrWord);
endinterface

// Diagnostic registers and readback
module diagRegs
  import mseqUwordPkg::*;
  import mseqDiagPkg::*;
(
  input  logic                   CLK,
  input  logic                   rstN,
  input  diagFunc_t              diagFunc,
  input  logic [`MSEQ_DIAG_W-1:0] diagWrData,
  input  logic [`MSEQ_ADR_W-1:0] crAdr,
  input  logic [`MSEQ_ADR_W-1:0] retAdr,
  input  logic [`MSEQ_SP_W-1:0]  spOut,
  input  logic                   dispParity,
  input  logic                   run,
  diagIf.regs                    diag,
  output logic [`MSEQ_DIAG_W-1:0] diagRdData
);

  typedef logic [`MSEQ_DIAG_W-1:0] diagByte_t;

  // Staged low bytes of the microword
  diagByte_t wrByte0;
  diagByte_t wrByte1;
  diagStat_t stat;

  //////////////////////////////////////////////////////////////////////
  // Diagnostic address
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      diag.diagAdr <= '0;
    end else if (diagFunc == DF_ADR_HI) begin
      diag.diagAdr[`MSEQ_ADR_W-1:`MSEQ_DIAG_W] <=
        diagWrData[`MSEQ_ADR_W-`MSEQ_DIAG_W-1:0];
    end else if (diagFunc == DF_ADR_LO) begin
      diag.diagAdr[`MSEQ_DIAG_W-1:0] <= diagWrData;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Microword write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (diagFunc == DF_WR_B0) begin
      wrByte0 <= diagWrData;
    end
    if (diagFunc == DF_WR_B1) begin
      wrByte1 <= diagWrData;
    end
  end

  // Third byte goes straight into the word on the commit edge
  assign diag.wrEn   = (diagFunc == DF_WR_B2);
  assign diag.wrAdr  = diag.diagAdr;
  assign diag.wrWord = uword_t'({diagWrData, wrByte1, wrByte0});

  //////////////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////////////

  assign stat = '{pad: '0, parity: dispParity, sp: spOut, run: run};

  // Zero for every non-read code
  always_comb begin
    case (diagFunc)
      DF_RD_ADR_LO: diagRdData = crAdr[`MSEQ_DIAG_W-1:0];
      DF_RD_ADR_HI: diagRdData = diagByte_t'(crAdr[`MSEQ_ADR_W-1:`MSEQ_DIAG_W]);
      DF_RD_RET_LO: diagRdData = retAdr[`MSEQ_DIAG_W-1:0];
      DF_RD_RET_HI: diagRdData = diagByte_t'(retAdr[`MSEQ_ADR_W-1:`MSEQ_DIAG_W]);
      DF_RD_STAT:   diagRdData = stat;
      default:      diagRdData = '0;
    endcase
  end

endmodule

// File: verilog/sbrStack.sv
`timescale 1ns/10ps
`include "mseq_settings.svh"

// Sequencer to stack link
interface sbrIf;
  logic                   push;
  logic                   pop;
  logic [`MSEQ_ADR_W-1:0] pushAdr;
  // Registered top of stack
  logic [`MSEQ_ADR_W-1:0] retAdr;

  modport seq (output push, output pop, output pushAdr, input retAdr);
  modport stack (input push, input pop, input pushAdr, output retAdr);
endinterface

// Subroutine call/return stack
// sp points at the next free entry and wraps at the depth
module sbrStack (
  input  logic                  CLK,
  input  logic                  rstN,
  sbrIf.stack                   sbr,
  output logic [`MSEQ_SP_W-1:0] spOut
);

  logic [`MSEQ_ADR_W-1:0] stackMem [`MSEQ_STACK_DEPTH];
  logic [`MSEQ_SP_W-1:0]  sp;
  logic [`MSEQ_SP_W-1:0]  wrPtr;
  logic [`MSEQ_SP_W-1:0]  rdPtr;
  // Push and pop together means force
  logic                   reload;

  assign reload = sbr.push & sbr.pop;
  // Reload restarts the stack at entry 0
  assign wrPtr  = reload ? '0 : sp;
  // Entry below the one being popped becomes the new top
  assign rdPtr  = sp - 2'd2;

  // Stack array
  always_ff @(posedge CLK) begin
    if (sbr.push) begin
      stackMem[wrPtr] <= sbr.pushAdr;
    end
  end

  // Pointer and return register
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      sp         <= '0;
      sbr.retAdr <= '0;
    end else if (reload) begin
      sp         <= {{(`MSEQ_SP_W-1){1'b0}}, 1'b1};
      sbr.retAdr <= sbr.pushAdr;
    end else if (sbr.push) begin
      sp         <= sp + 1'b1;
      sbr.retAdr <= sbr.pushAdr;
    end else if (sbr.pop) begin
      sp         <= sp - 1'b1;
      sbr.retAdr <= stackMem[rdPtr];
    end
  end

  assign spOut = sp;

endmodule

// File: verilog/mseqDiagPkg.sv
`include "mseq_settings.svh"

package mseqDiagPkg;

  // Diagnostic function codes
  typedef enum logic [3:0] {
    DF_IDLE      = 4'd0,
    // Load diagnostic address, upper 3 bits then lower 8
    DF_ADR_HI    = 4'd1,
    DF_ADR_LO    = 4'd2,
    // Microword bytes low to high, B2 commits the word
    DF_WR_B0     = 4'd3,
    DF_WR_B1     = 4'd4,
    DF_WR_B2     = 4'd5,
    // Readback of crAdr and sbrRet halves
    DF_RD_ADR_LO = 4'd6,
    DF_RD_ADR_HI = 4'd7,
    DF_RD_RET_LO = 4'd8,
    DF_RD_RET_HI = 4'd9,
    DF_RD_STAT   = 4'd10
  } diagFunc_t;

  // Status byte returned by DF_RD_STAT
  typedef struct packed {
    logic [`MSEQ_DIAG_W-`MSEQ_SP_W-3:0] pad;
    logic                               parity;
    logic [`MSEQ_SP_W-1:0]              sp;
    logic                               run;
  } diagStat_t;

endpackage

// File: verilog/mseqUwordPkg.sv
`include "mseq_settings.svh"

package mseqUwordPkg;

  //////////////////////////////////////////////////////////////////////
  // Dispatch source select
  //////////////////////////////////////////////////////////////////////

  // Codes 5 to 7 are unused and behave like DISP_NONE
  typedef enum logic [2:0] {
    DISP_NONE = 3'd0,
    // Selected condIn bit into address bit 0
    DISP_SKIP = 3'd1,
    // Instruction dispatch nibble into bits 4..1
    DISP_IRJ  = 3'd2,
    // Top of call/return stack
    DISP_RET  = 3'd3,
    // Diagnostic address register
    DISP_DIAG = 3'd4
  } dispCode_t;

  //////////////////////////////////////////////////////////////////////
  // Microword layout, 24 bits
  //////////////////////////////////////////////////////////////////////

  // Bits 23..13 jump, 12..10 disp, 9 call, 8..6 cond, 5..0 uOut
  typedef struct packed {
    // Base of next address
    logic [`MSEQ_ADR_W-1:0] jump;
    dispCode_t              disp;
    // Push current address on the stack
    logic                   call;
    // Skip condition select
    logic [2:0]             cond;
    // Control bits to the rest of the machine
    logic [5:0]             uOut;
  } uword_t;

endpackage

// File: verilog/mseq_settings.svh
`ifndef MSEQ_SETTINGS_SVH
`define MSEQ_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Sequencer sizing
//////////////////////////////////////////////////////////////////////

// Control-RAM address width, 2K words
`define MSEQ_ADR_W 11

// Number of control-store words
`define MSEQ_CRAM_WORDS (1 << `MSEQ_ADR_W)

// Subroutine stack entries
`define MSEQ_STACK_DEPTH 16

// Stack pointer width
`define MSEQ_SP_W $clog2(`MSEQ_STACK_DEPTH)

// Diagnostic data path is one byte wide
`define MSEQ_DIAG_W 8

`endif
